//--- source/l1b_bus_pkg.sv
`default_nettype none

// CPU bus cycle and host bus definitions shared by the whole board model
package l1b_bus_pkg;

  // One 65816 bus cycle as seen at the end of phi1
  // The bank byte comes from the multiplexed data bus
  typedef struct packed {
    logic [7:0]  bank;
    logic [15:0] addr;
    logic        vda;
    logic        vpa;
    logic        rnw;
    logic [7:0]  wdata;
  } cpu_cycle_t;

  // Signals driven towards the host side of the connector
  typedef struct packed {
    logic       addr15;
    logic       addr14;
    logic       rnw;
    logic [7:0] wdata;
    logic       wdata_en;
  } bbc_bus_t;

  // On-board RAM chip enable (active low) and address lines 18..16
  typedef struct packed {
    logic       ceb;
    logic [2:0] addr_hi;
  } ram_sel_t;

  // Host address of the paged ROM select register
  localparam logic [15:0] BBC_PAGED_ROM_SEL = 16'hFE30;
  // Bits forced high in the bank byte on a remap, landing in bank FE
  localparam logic [7:0] REMAP_BANK_MASK = 8'hFE;
  // Value the CPU read bus carries when nothing drives it
  localparam logic [7:0] CPU_RDATA_IDLE = 8'h00;

endpackage

`default_nettype wire

//--- source/l1b_map_pkg.sv
`default_nettype none

// Layout of the map/clock register and the register selects
package l1b_map_pkg;

  // The map register, top bit first
  // hsclk_srst_b holds the clock switcher in reset while low
  typedef struct packed {
    logic       hsclk_srst_b;
    logic       hsclk_en;
    logic       rom_en;
    logic       ram_en;
    logic [1:0] hsclk_div;
    logic [1:0] cpuclk_div;
  } map_reg_t;

  // Qualified write strobes for the two internal registers
  typedef struct packed {
    logic map_cc;
    logic pagereg;
  } reg_sel_t;

  // Fields handed on to the external clock divider
  typedef struct packed {
    logic       hsclk_srst_b;
    logic [1:0] hsclk_div;
    logic [1:0] cpuclk_div;
  } clk_cfg_t;

  // Only the low four ROM select bits of FE30 are kept
  localparam int PAGEREG_SZ = 4;

  // BASIC is assumed to live in the top ROM slot
  localparam logic [PAGEREG_SZ-1:0] BASICROM_NUMBER = 4'hF;

endpackage

`default_nettype wire

//--- source/l1b_ctrl.sv
`timescale 1ns/10ps
`default_nettype none

module l1b_ctrl (
  input  logic                   cpu_ck_phi1_w,
  input  logic                   resetb,
  input  l1b_bus_pkg::cpu_cycle_t cyc,
  input  l1b_map_pkg::map_reg_t   map,
  input  logic                   hiaddr_msb,
  output l1b_map_pkg::reg_sel_t   reg_wr,
  output logic                   map_rd,
  output logic                   hsclk_sel
);

  import l1b_bus_pkg::*;

  logic map_cc_sel;
  logic pagereg_sel;
  logic mem_cyc;
  logic hsclk_sel_q;

  // ----------------------------------------
  // Register decode
  // ----------------------------------------

  // Banks 80..BF with address bits 1:0 set hit the map register
  assign map_cc_sel = cyc.vda && (cyc.bank[7:6] == 2'b10) && (cyc.addr[1:0] == 2'b11);

  // The ROM select write is snooped on its way to the host
  // Only direct low-memory accesses count, never the high banks
  assign pagereg_sel = cyc.vda && !cyc.bank[7] && (cyc.addr == BBC_PAGED_ROM_SEL);

  // Strobes are qualified by direction here so the register block just loads
  assign reg_wr.map_cc  = map_cc_sel && !cyc.rnw;
  assign reg_wr.pagereg = pagereg_sel && !cyc.rnw;
  assign map_rd         = map_cc_sel && cyc.rnw;

  // ----------------------------------------
  // High-speed clock selection
  // ----------------------------------------

  // Any cycle that puts a valid address on the bus
  assign mem_cyc = cyc.vda || cyc.vpa;

  always_comb
  begin
    if (!map.hsclk_en)
      hsclk_sel = 1'b0;
    // Opcode fetch decides the speed from where the code lives
    else if (cyc.vpa && cyc.vda && cyc.rnw)
      hsclk_sel = hiaddr_msb;
    // Direct data accesses to high memory keep the current clock
    else if (cyc.bank[7] && mem_cyc)
      hsclk_sel = hsclk_sel_q;
    // Remapped reads keep the current clock
    else if (hiaddr_msb && cyc.rnw && mem_cyc)
      hsclk_sel = hsclk_sel_q;
    // Remapped accesses to the bottom 8K also keep it
    else if (hiaddr_msb && (cyc.addr[15:13] == 3'b000) && mem_cyc)
      hsclk_sel = hsclk_sel_q;
    // Internal cycles never change the clock
    else if (!cyc.vda && !cyc.vpa)
      hsclk_sel = hsclk_sel_q;
    // Everything else talks to the host, so fall back to the host clock
    else
      hsclk_sel = 1'b0;
  end

  // The choice is held across the edge so the next cycle can keep it
  always_ff @(posedge cpu_ck_phi1_w or negedge resetb)
  begin
    if (!resetb)
      hsclk_sel_q <= 1'b0;
    else
      hsclk_sel_q <= hsclk_sel;
  end

endmodule

`default_nettype wire

//--- source/l1b_remap.sv
`timescale 1ns/10ps
`default_nettype none

module l1b_remap (
  input  l1b_bus_pkg::cpu_cycle_t                cyc,
  input  l1b_map_pkg::map_reg_t                  map,
  input  logic [l1b_map_pkg::PAGEREG_SZ-1:0]     pagereg,
  output logic                                  hiaddr_msb,
  output l1b_bus_pkg::ram_sel_t                  ram,
  output logic                                  bbc_addr15,
  output logic                                  bbc_addr14,
  output logic                                  bbc_rnw
);

  import l1b_bus_pkg::*;
  import l1b_map_pkg::*;

  logic       mem_cyc;
  logic       rom_remap;
  logic       ram_remap;
  logic       dummy;
  logic [7:0] hiaddr;

  assign mem_cyc = cyc.vda || cyc.vpa;

  // ----------------------------------------
  // Remap decode
  // ----------------------------------------

  // MOS ROM is copied from C000 to FBFF, which leaves the IO pages
  // and the vectors on the host
  // The paged slot at 8000 only moves while BASIC is selected
  always_comb
  begin
    rom_remap = 1'b0;
    if (map.rom_en && !cyc.bank[7] && cyc.addr[15] && mem_cyc)
    begin
      if (cyc.addr[14] && !(&cyc.addr[13:10]))
        rom_remap = 1'b1;
      else if (!cyc.addr[14] && (pagereg == BASICROM_NUMBER))
        rom_remap = 1'b1;
    end
  end

  // The whole 32K of host RAM moves when enabled
  assign ram_remap = map.ram_en && !cyc.bank[7] && !cyc.addr[15] && mem_cyc;

  // Remapped cycles end up in bank FE of the on-board RAM
  assign hiaddr     = cyc.bank | ((rom_remap || ram_remap) ? REMAP_BANK_MASK : 8'h00);
  assign hiaddr_msb = hiaddr[7];

  // ----------------------------------------
  // RAM and host address lines
  // ----------------------------------------

  // Banks C0 and up are served by the on-board RAM
  assign ram.ceb     = !(mem_cyc && (hiaddr[7:6] == 2'b11));
  assign ram.addr_hi = hiaddr[2:0];

  // A direct high-memory access still runs a host cycle, so turn it
  // into a harmless read of the ROM area
  assign dummy = cyc.bank[7];

  assign bbc_addr15 = dummy ? 1'b1 : cyc.addr[15];
  assign bbc_addr14 = dummy ? 1'b0 : cyc.addr[14];
  assign bbc_rnw    = cyc.rnw || dummy;

endmodule

`default_nettype wire

//--- source/l1b_regs.sv
`timescale 1ns/10ps
`default_nettype none

module l1b_regs (
  input  logic                               cpu_ck_phi1_w,
  input  logic                               resetb,
  input  l1b_map_pkg::reg_sel_t               reg_wr,
  input  logic [7:0]                         wdata,
  output l1b_map_pkg::map_reg_t               map,
  output logic [l1b_map_pkg::PAGEREG_SZ-1:0]  pagereg,
  output l1b_map_pkg::clk_cfg_t               clk_cfg
);

  import l1b_map_pkg::*;

  map_reg_t              map_q;
  logic [PAGEREG_SZ-1:0] pagereg_q;

  // Both registers load at the edge that closes the write cycle
  // The map register comes out of reset with every feature off
  always_ff @(posedge cpu_ck_phi1_w or negedge resetb)
  begin
    if (!resetb)
    begin
      map_q     <= '0;
      pagereg_q <= '0;
    end
    else
    begin
      if (reg_wr.map_cc)
        map_q <= map_reg_t'(wdata);
      // Shadow of FE30, only the slot number bits matter
      if (reg_wr.pagereg)
        pagereg_q <= wdata[PAGEREG_SZ-1:0];
    end
  end

  assign map     = map_q;
  assign pagereg = pagereg_q;

  // Clock fields for the divider outside this model
  assign clk_cfg.hsclk_srst_b = map_q.hsclk_srst_b;
  assign clk_cfg.hsclk_div    = map_q.hsclk_div;
  assign clk_cfg.cpuclk_div   = map_q.cpuclk_div;

endmodule

`default_nettype wire

//--- source/l1b_data_steer.sv
`timescale 1ns/10ps
`default_nettype none

module l1b_data_steer (
  input  l1b_bus_pkg::cpu_cycle_t cyc,
  input  logic                   bbc_rnw,
  input  logic                   hiaddr_msb,
  input  logic                   map_rd,
  input  l1b_map_pkg::map_reg_t   map,
  input  logic [7:0]             bbc_rdata,
  output logic [7:0]             cpu_rdata,
  output logic                   cpu_rdata_en,
  output logic [7:0]             bbc_wdata,
  output logic                   bbc_wdata_en
);

  import l1b_bus_pkg::*;

  // ----------------------------------------
  // Read path to the CPU
  // ----------------------------------------

  // The map register wins over the host bus
  // High-memory reads are answered by the RAM itself, so the glue stays off
  always_comb
  begin
    if (map_rd)
    begin
      cpu_rdata    = map;
      cpu_rdata_en = 1'b1;
    end
    else if (cyc.rnw && !hiaddr_msb)
    begin
      cpu_rdata    = bbc_rdata;
      cpu_rdata_en = 1'b1;
    end
    else
    begin
      cpu_rdata    = CPU_RDATA_IDLE;
      cpu_rdata_en = 1'b0;
    end
  end

  // ----------------------------------------
  // Write path to the host
  // ----------------------------------------

  // The host only sees write data when its own rnw says write,
  // which already excludes dummy cycles
  assign bbc_wdata    = cyc.wdata;
  assign bbc_wdata_en = !bbc_rnw;

endmodule

`default_nettype wire

//--- source/l1b_top.sv
`timescale 1ns/10ps
`default_nettype none

module l1b_top (
  input  logic                   cpu_ck_phi1_w,
  input  logic                   resetb,
  input  l1b_bus_pkg::cpu_cycle_t cyc,
  input  logic [7:0]             bbc_rdata,
  output l1b_bus_pkg::ram_sel_t   ram,
  output l1b_bus_pkg::bbc_bus_t   bbc,
  output logic [7:0]             cpu_rdata,
  output logic                   cpu_rdata_en,
  output logic                   hsclk_sel,
  output l1b_map_pkg::clk_cfg_t   clk_cfg
);

  l1b_map_pkg::map_reg_t              map;
  logic [l1b_map_pkg::PAGEREG_SZ-1:0] pagereg;
  l1b_map_pkg::reg_sel_t              reg_wr;
  logic                               map_rd;
  logic                               hiaddr_msb;
  logic                               bbc_addr15;
  logic                               bbc_addr14;
  logic                               bbc_rnw;
  logic [7:0]                         bbc_wdata;
  logic                               bbc_wdata_en;

  // Register decode and clock selection
  l1b_ctrl i_l1b_ctrl (
    .cpu_ck_phi1_w (cpu_ck_phi1_w),
    .resetb        (resetb),
    .cyc           (cyc),
    .map           (map),
    .hiaddr_msb    (hiaddr_msb),
    .reg_wr        (reg_wr),
    .map_rd        (map_rd),
    .hsclk_sel     (hsclk_sel)
  );

  // Bank remapping, RAM select and host address
  l1b_remap i_l1b_remap (
    .cyc        (cyc),
    .map        (map),
    .pagereg    (pagereg),
    .hiaddr_msb (hiaddr_msb),
    .ram        (ram),
    .bbc_addr15 (bbc_addr15),
    .bbc_addr14 (bbc_addr14),
    .bbc_rnw    (bbc_rnw)
  );

  // Map register and ROM select shadow
  l1b_regs i_l1b_regs (
    .cpu_ck_phi1_w (cpu_ck_phi1_w),
    .resetb        (resetb),
    .reg_wr        (reg_wr),
    .wdata         (cyc.wdata),
    .map           (map),
    .pagereg       (pagereg),
    .clk_cfg       (clk_cfg)
  );

  // Data in both directions
  l1b_data_steer i_l1b_data_steer (
    .cyc          (cyc),
    .bbc_rnw      (bbc_rnw),
    .hiaddr_msb   (hiaddr_msb),
    .map_rd       (map_rd),
    .map          (map),
    .bbc_rdata    (bbc_rdata),
    .cpu_rdata    (cpu_rdata),
    .cpu_rdata_en (cpu_rdata_en),
    .bbc_wdata    (bbc_wdata),
    .bbc_wdata_en (bbc_wdata_en)
  );

  // Collect the host side into one bundle
  assign bbc.addr15   = bbc_addr15;
  assign bbc.addr14   = bbc_addr14;
  assign bbc.rnw      = bbc_rnw;
  assign bbc.wdata    = bbc_wdata;
  assign bbc.wdata_en = bbc_wdata_en;

endmodule

`default_nettype wire

//--- testbench/l1b_properties.sv
`timescale 1ns/10ps
`default_nettype none

module l1b_properties (
  input logic                    cpu_ck_phi1_w,
  input logic                    resetb,
  input l1b_bus_pkg::cpu_cycle_t cyc,
  input l1b_map_pkg::map_reg_t   map,
  input l1b_bus_pkg::bbc_bus_t   bbc,
  input l1b_bus_pkg::ram_sel_t   ram,
  input logic                    cpu_rdata_en,
  input logic                    hsclk_sel
);

  // A direct high-memory access must never write to the host
  dummy_is_read: assert property (@(posedge cpu_ck_phi1_w) disable iff (!resetb)
    cyc.bank[7] |-> bbc.rnw)
    else $error("Host rnw low during a bank 80+ access");

  // With the high-speed clock disabled the selection stays on the host clock
  hsclk_off: assert property (@(posedge cpu_ck_phi1_w) disable iff (!resetb)
    !map.hsclk_en |-> !hsclk_sel)
    else $error("High-speed clock selected while it is disabled");

  // The glue and the on-board RAM must not both drive the CPU data bus
  no_read_contention: assert property (@(posedge cpu_ck_phi1_w) disable iff (!resetb)
    (cyc.rnw && cyc.bank[7] && (cyc.vda || cyc.vpa)) |-> !(cpu_rdata_en && !ram.ceb))
    else $error("Read data driven by both the glue and the RAM");

endmodule

bind l1b_top l1b_properties i_l1b_properties (
  .cpu_ck_phi1_w (cpu_ck_phi1_w),
  .resetb        (resetb),
  .cyc           (cyc),
  .map           (map),
  .bbc           (bbc),
  .ram           (ram),
  .cpu_rdata_en  (cpu_rdata_en),
  .hsclk_sel     (hsclk_sel)
);

`default_nettype wire

//--- testbench/l1b_tb.sv
`timescale 1ns/10ps
`default_nettype none

module l1b_tb;

  import l1b_bus_pkg::*;
  import l1b_map_pkg::*;

  localparam int CLK_PERIOD  = 10;
  localparam int NUM_TESTS   = 6;
  // Each test gets a budget of 50 bus cycles
  localparam int WATCHDOG_NS = NUM_TESTS * 50 * CLK_PERIOD;

  logic       cpu_ck_phi1_w = 1'b0;
  logic       resetb;
  cpu_cycle_t cyc;
  logic [7:0] bbc_rdata;
  ram_sel_t   ram;
  bbc_bus_t   bbc;
  logic [7:0] cpu_rdata;
  logic       cpu_rdata_en;
  logic       hsclk_sel;
  clk_cfg_t   clk_cfg;
  integer     seed = 93338;
  int         errors = 0;
  int         checks = 0;
  int         tests_run = 0;

  l1b_top i_l1b_top (
    .cpu_ck_phi1_w (cpu_ck_phi1_w),
    .resetb        (resetb),
    .cyc           (cyc),
    .bbc_rdata     (bbc_rdata),
    .ram           (ram),
    .bbc           (bbc),
    .cpu_rdata     (cpu_rdata),
    .cpu_rdata_en  (cpu_rdata_en),
    .hsclk_sel     (hsclk_sel),
    .clk_cfg       (clk_cfg)
  );

  always #(CLK_PERIOD / 2) cpu_ck_phi1_w = ~cpu_ck_phi1_w;

  // ----------------------------------------
  // Stimulus helpers
  // ----------------------------------------

  function automatic logic [7:0] rand_byte();
    int r;
    r = $random(seed);
    return r[7:0];
  endfunction

  // One bus cycle starts at the rising edge and is sampled at the falling edge
  task automatic bus_cycle(input logic [7:0] bank, input logic [15:0] addr,
                           input logic vda, input logic vpa, input logic rnw,
                           input logic [7:0] wdata, input logic [7:0] rdata);
    @(posedge cpu_ck_phi1_w);
    cyc       <= cpu_cycle_t'{bank, addr, vda, vpa, rnw, wdata};
    bbc_rdata <= rdata;
    @(negedge cpu_ck_phi1_w);
  endtask

  // The map register answers at any bank 80..BF address ending in 3
  task automatic write_map(input logic [7:0] value);
    bus_cycle(8'h80, 16'h0003, 1'b1, 1'b0, 1'b0, value, 8'h00);
  endtask

  task automatic finish_test(input string name, input int errors_before);
    tests_run++;
    $display("Test %s finished with %0d errors", name, errors - errors_before);
  endtask

  // ----------------------------------------
  // Compare tasks
  // ----------------------------------------

  task automatic check_ram(input ram_sel_t exp);
    checks++;
    if (ram !== exp)
    begin
      errors++;
      $display("Fail ram: got 0x%h expected 0x%h", ram, exp);
    end
  endtask

  task automatic check_bbc(input bbc_bus_t exp);
    checks++;
    if (bbc !== exp)
    begin
      errors++;
      $display("Fail bbc: got 0x%h expected 0x%h", bbc, exp);
    end
  endtask

  task automatic check_rdata(input logic [7:0] exp_data, input logic exp_en);
    checks++;
    if ((cpu_rdata !== exp_data) || (cpu_rdata_en !== exp_en))
    begin
      errors++;
      $display("Fail cpu_rdata/cpu_rdata_en: got 0x%h/0x%h expected 0x%h/0x%h",
               cpu_rdata, cpu_rdata_en, exp_data, exp_en);
    end
  endtask

  task automatic check_clk_cfg(input clk_cfg_t exp);
    checks++;
    if (clk_cfg !== exp)
    begin
      errors++;
      $display("Fail clk_cfg: got 0x%h expected 0x%h", clk_cfg, exp);
    end
  endtask

  task automatic check_bit(input string name, input logic got, input logic exp);
    checks++;
    if (got !== exp)
    begin
      errors++;
      $display("Fail %s: got 0x%h expected 0x%h", name, got, exp);
    end
  endtask

  // ----------------------------------------
  // Directed tests
  // ----------------------------------------

  task automatic test_reset_readback();
    int         err0;
    logic [7:0] value;
    map_reg_t   m;
    err0  = errors;
    value = rand_byte();
    m     = map_reg_t'(value);
    bus_cycle(8'h80, 16'h0003, 1'b1, 1'b0, 1'b1, 8'h00, rand_byte());
    check_rdata(8'h00, 1'b1);
    check_clk_cfg(clk_cfg_t'(5'h00));
    write_map(value);
    bus_cycle(8'h80, 16'h0003, 1'b1, 1'b0, 1'b1, 8'h00, rand_byte());
    check_rdata(value, 1'b1);
    // The divider sees the reset, high-speed and CPU divide fields
    check_clk_cfg(clk_cfg_t'{m.hsclk_srst_b, m.hsclk_div, m.cpuclk_div});
    finish_test("reset_readback", err0);
  endtask

  task automatic test_ram_remap();
    int         err0;
    logic [7:0] rdata;
    err0 = errors;
    write_map(8'h10);
    // Bank FE puts 110 on RAM address lines 18..16
    bus_cycle(8'h00, 16'h1234, 1'b1, 1'b0, 1'b1, 8'h00, rand_byte());
    check_ram(ram_sel_t'{1'b0, 3'h6});
    check_rdata(8'h00, 1'b0);
    write_map(8'h00);
    rdata = rand_byte();
    bus_cycle(8'h00, 16'h1234, 1'b1, 1'b0, 1'b1, 8'h00, rdata);
    check_ram(ram_sel_t'{1'b1, 3'h0});
    check_rdata(rdata, 1'b1);
    finish_test("ram_remap", err0);
  endtask

  task automatic test_rom_remap();
    int         err0;
    logic [7:0] rdata;
    err0  = errors;
    rdata = rand_byte();
    write_map(8'h20);
    bus_cycle(8'h00, 16'hC000, 1'b1, 1'b0, 1'b1, 8'h00, rand_byte());
    check_ram(ram_sel_t'{1'b0, 3'h6});
    // FC00 and up holds the IO pages and stays on the host
    bus_cycle(8'h00, 16'hFC00, 1'b1, 1'b0, 1'b1, 8'h00, rdata);
    check_ram(ram_sel_t'{1'b1, 3'h0});
    check_rdata(rdata, 1'b1);
    // Select the BASIC slot through the ROM select register
    bus_cycle(8'h00, 16'hFE30, 1'b1, 1'b0, 1'b0, 8'h0F, 8'h00);
    bus_cycle(8'h00, 16'h8000, 1'b1, 1'b0, 1'b1, 8'h00, rand_byte());
    check_ram(ram_sel_t'{1'b0, 3'h6});
    bus_cycle(8'h00, 16'hFE30, 1'b1, 1'b0, 1'b0, 8'h03, 8'h00);
    bus_cycle(8'h00, 16'h8000, 1'b1, 1'b0, 1'b1, 8'h00, rdata);
    check_ram(ram_sel_t'{1'b1, 3'h0});
    check_rdata(rdata, 1'b1);
    finish_test("rom_remap", err0);
  endtask

  task automatic test_dummy_access();
    int         err0;
    logic [7:0] wdata;
    err0  = errors;
    wdata = rand_byte();
    // Host sees address bits 15:14 as 10 and a read in both cases
    bus_cycle(8'h80, 16'h1234, 1'b1, 1'b0, 1'b1, wdata, rand_byte());
    check_bbc(bbc_bus_t'{1'b1, 1'b0, 1'b1, wdata, 1'b0});
    check_bit("cpu_rdata_en", cpu_rdata_en, 1'b0);
    bus_cycle(8'h80, 16'h5678, 1'b1, 1'b0, 1'b0, wdata, rand_byte());
    check_bbc(bbc_bus_t'{1'b1, 1'b0, 1'b1, wdata, 1'b0});
    check_bit("cpu_rdata_en", cpu_rdata_en, 1'b0);
    finish_test("dummy_access", err0);
  endtask

  task automatic test_clock_select();
    int err0;
    err0 = errors;
    write_map(8'h70);
    // Opcode fetch from remapped RAM switches to the fast clock
    bus_cycle(8'h00, 16'h1000, 1'b1, 1'b1, 1'b1, 8'h00, rand_byte());
    check_bit("hsclk_sel", hsclk_sel, 1'b1);
    bus_cycle(8'h00, 16'h2000, 1'b1, 1'b0, 1'b1, 8'h00, rand_byte());
    check_bit("hsclk_sel", hsclk_sel, 1'b1);
    // The IO pages are host accesses and drop back to the slow clock
    bus_cycle(8'h00, 16'hFE40, 1'b1, 1'b0, 1'b1, 8'h00, rand_byte());
    check_bit("hsclk_sel", hsclk_sel, 1'b0);
    write_map(8'h30);
    bus_cycle(8'h00, 16'h1000, 1'b1, 1'b1, 1'b1, 8'h00, rand_byte());
    check_bit("hsclk_sel", hsclk_sel, 1'b0);
    finish_test("clock_select", err0);
  endtask

  task automatic test_host_write();
    int         err0;
    logic [7:0] wdata;
    err0  = errors;
    wdata = rand_byte();
    write_map(8'h00);
    bus_cycle(8'h00, 16'h4321, 1'b1, 1'b0, 1'b0, wdata, rand_byte());
    check_bbc(bbc_bus_t'{1'b0, 1'b1, 1'b0, wdata, 1'b1});
    check_ram(ram_sel_t'{1'b1, 3'h0});
    finish_test("host_write", err0);
  endtask

  // ----------------------------------------
  // Sequence and watchdog
  // ----------------------------------------

  initial
  begin
    resetb    = 1'b0;
    cyc       = '0;
    bbc_rdata = 8'h00;
    repeat (5) @(posedge cpu_ck_phi1_w);
    resetb <= 1'b1;
    test_reset_readback();
    test_ram_remap();
    test_rom_remap();
    test_dummy_access();
    test_clock_select();
    test_host_write();
    $display("Tests run: %0d, checks: %0d, errors: %0d", tests_run, checks, errors);
    if (errors == 0)
      $display("ALL CHECKS PASSED");
    else
      $display("CHECKS FAILED");
    $finish;
  end

  initial
  begin
    #(WATCHDOG_NS);
    $display("Watchdog expired after %0d ns, the tests did not finish", WATCHDOG_NS);
    $display("CHECKS FAILED");
    $finish;
  end

endmodule

`default_nettype wire

//--- files.f
source/l1b_bus_pkg.sv
source/l1b_map_pkg.sv
source/l1b_ctrl.sv
source/l1b_remap.sv
source/l1b_regs.sv
source/l1b_data_steer.sv
source/l1b_top.sv
testbench/l1b_properties.sv
testbench/l1b_tb.sv

//--- run.sh
#!/bin/sh
# Build and run the testbench with Verilator, then look for the pass line
set -e
cd "$(dirname "$0")"
verilator --binary --timing --assert --top-module l1b_tb -f files.f -o l1b_sim
./obj_dir/l1b_sim | tee sim.log
grep -q "^ALL CHECKS PASSED$" sim.log
